// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := can_decoder_tb
FILELIST  := can_decoder.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== can_decoder.f ====
source/can_frame_pkg.sv
source/can_decoder_pkg.sv
source/can_destuffer.sv
source/can_crc15.sv
source/can_bit_counter.sv
source/can_frame_fsm.sv
source/can_field_capture.sv
source/can_decoder.sv
tests/can_decoder_checker.sv
tests/can_decoder_tb.sv

// ==== source/can_bit_counter.sv ====
`timescale 1ns/1ps

module can_bit_counter
	import can_frame_pkg::*;
	import can_decoder_pkg::*;
(
	input  logic           clock,
	input  logic           reset,
	input  logic           sample_point,
	input  logic           stuff_bit,
	input  decoder_state_t state,
	output field_len_t     bit_count	// Bits already seen in this field
);

	// Longest field is the data field
	localparam field_len_t COUNT_MAX = field_len_t'(MAX_DATA_BYTES * 8);

	decoder_state_t prev_state;	// State one clock ago
	field_len_t     count;
	logic           new_field;	// First clock in a new state
	logic           bit_valid;	// Sampled bit that belongs to the field

	assign new_field = (state != prev_state);
	assign bit_valid = sample_point & ~stuff_bit;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			prev_state <= st_idle;
			count      <= '0;
		end
		else
		begin
			prev_state <= state;
			if (new_field)
				count <= bit_valid ? field_len_t'(1) : field_len_t'(0);	// Restart
			else if (bit_valid && count != COUNT_MAX)
				count <= count + 7'd1;	// Saturates in long idle periods
		end
	end

	// Old count is stale on the first clock of a field
	assign bit_count = new_field ? field_len_t'(0) : count;

	// Data field ends on its 64th bit at the latest
	assert property (@(posedge clock) disable iff (reset)
		(state == st_data) |-> (bit_count < COUNT_MAX));

endmodule

// ==== source/can_crc15.sv ====
`timescale 1ns/1ps

module can_crc15
	import can_frame_pkg::*;
(
	input  logic clock,
	input  logic reset,
	input  logic rx_bit,
	input  logic sample_point,
	input  logic crc_clear,		// Held while the bus is idle
	input  logic crc_enable,	// SOF up to the last data bit, stuff bits excluded
	output crc_t crc
);

	logic feedback;	// Incoming bit against the register MSB

	assign feedback = rx_bit ^ crc[LEN_CRC-1];

	// ==================================================
	// Serial CRC register
	// ==================================================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			crc <= '0;
		else if (crc_clear)
			crc <= '0;	// Start value for the next frame
		else if (sample_point && crc_enable)
		begin
			// Shift left and fold in the polynomial
			if (feedback)
				crc <= {crc[LEN_CRC-2:0], 1'b0} ^ CRC_POLY;
			else
				crc <= {crc[LEN_CRC-2:0], 1'b0};
		end
	end

endmodule

// ==== source/can_decoder.sv ====
`timescale 1ns/1ps

module can_decoder
	import can_frame_pkg::*;
	import can_decoder_pkg::*;
#(
	parameter int FLAGS_MIN = 6,
	parameter int FLAGS_MAX = 12,
	parameter int DELIM_LEN = 8
)
(
	input  logic       clock,
	input  logic       reset,
	input  logic       rx_bit,
	input  logic       sample_point,	// One strobe per bus bit
	output can_frame_t frame,			// Valid from frame_received to next SOF
	output logic       frame_received,
	output logic       error_out
);

	logic           stuff_active;
	logic           stuff_bit;
	logic           stuff_error;
	logic           crc_clear;
	logic           crc_enable;
	logic           rtr_srr_bit;
	decoder_state_t state;
	field_len_t     bit_count;
	crc_t           crc;		// Computed CRC

	// ==================================================
	// Bit level
	// ==================================================

	can_destuffer u_destuffer (
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.sample_point (sample_point),
		.stuff_active (stuff_active),
		.stuff_bit    (stuff_bit),
		.stuff_error  (stuff_error)
	);

	can_crc15 u_crc15 (
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.sample_point (sample_point),
		.crc_clear    (crc_clear),
		.crc_enable   (crc_enable),
		.crc          (crc)
	);

	can_bit_counter u_bit_counter (
		.clock        (clock),
		.reset        (reset),
		.sample_point (sample_point),
		.stuff_bit    (stuff_bit),
		.state        (state),
		.bit_count    (bit_count)
	);

	// ==================================================
	// Frame level
	// ==================================================

	can_frame_fsm #(
		.FLAGS_MIN (FLAGS_MIN),
		.FLAGS_MAX (FLAGS_MAX),
		.DELIM_LEN (DELIM_LEN)
	) u_frame_fsm (
		.clock          (clock),
		.reset          (reset),
		.rx_bit         (rx_bit),
		.sample_point   (sample_point),
		.stuff_bit      (stuff_bit),
		.stuff_error    (stuff_error),
		.bit_count      (bit_count),
		.crc            (crc),
		.rx_crc         (frame.crc),
		.dlc            (frame.dlc),
		.ide            (frame.ide),
		.rtr_srr_bit    (rtr_srr_bit),
		.state          (state),
		.stuff_active   (stuff_active),
		.crc_clear      (crc_clear),
		.crc_enable     (crc_enable),
		.frame_received (frame_received),
		.error_out      (error_out)
	);

	can_field_capture u_field_capture (
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.sample_point (sample_point),
		.stuff_bit    (stuff_bit),
		.state        (state),
		.frame        (frame),
		.rtr_srr_bit  (rtr_srr_bit)
	);

endmodule

// ==== source/can_decoder_pkg.sv ====
package can_decoder_pkg;

	// ==================================================
	// Decoder state
	// ==================================================

	// One state per CAN field plus the error frame
	typedef enum logic [4:0] {
		st_idle,			// Bus idle, waiting for SOF
		st_id_a,
		st_rtr_srr,			// RTR in standard frames, SRR in extended ones
		st_ide,
		st_id_b,
		st_rtr,				// Extended frames only
		st_reserved1,		// Extended frames only
		st_reserved0,
		st_dlc,
		st_data,
		st_crc,
		st_crc_delim,
		st_ack_slot,
		st_ack_delim,
		st_eof,
		st_intermission,
		st_error_flags,		// Superposed error flags
		st_error_delim
	} decoder_state_t;

	// Bits counted so far in the current field
	typedef logic [6:0] field_len_t;

	// Why the decoder entered the error frame
	typedef enum logic [1:0] {
		err_none,
		err_stuff,
		err_form,
		err_crc
	} error_cause_t;

	// Bus levels
	localparam logic DOMINANT  = 1'b0;
	localparam logic RECESSIVE = 1'b1;

endpackage

// ==== source/can_destuffer.sv ====
`timescale 1ns/1ps

module can_destuffer
(
	input  logic clock,
	input  logic reset,
	input  logic rx_bit,
	input  logic sample_point,
	input  logic stuff_active,	// SOF up to the bit after the CRC
	output logic stuff_bit,		// Current sample is a stuff bit
	output logic stuff_error	// Sixth equal bit in a row
);

	logic [4:0] history;	// Last five raw bus bits, newest in bit 0
	logic       run_low;	// Five dominant bits seen
	logic       run_high;	// Five recessive bits seen

	// ==================================================
	// Raw bit history
	// ==================================================

	// Stuff bits are shifted in as well
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			history <= 5'b10101;	// Alternating so no run is pending
		else if (sample_point)
			history <= {history[3:0], rx_bit};
	end

	assign run_low  = (history == 5'b00000);
	assign run_high = (history == 5'b11111);

	// ==================================================
	// Stuff decision for the current sample
	// ==================================================

	// Opposite level after a run is the inserted bit
	assign stuff_bit   = sample_point & stuff_active &
		((run_low & rx_bit) | (run_high & ~rx_bit));

	// Same level again breaks the stuffing rule
	assign stuff_error = sample_point & stuff_active &
		((run_low & ~rx_bit) | (run_high & rx_bit));

	// A bit is either dropped or flagged, never both
	assert property (@(posedge clock) disable iff (reset) !(stuff_bit && stuff_error));

endmodule

// ==== source/can_field_capture.sv ====
`timescale 1ns/1ps

module can_field_capture
	import can_frame_pkg::*;
	import can_decoder_pkg::*;
(
	input  logic           clock,
	input  logic           reset,
	input  logic           rx_bit,
	input  logic           sample_point,
	input  logic           stuff_bit,
	input  decoder_state_t state,
	output can_frame_t     frame,
	output logic           rtr_srr_bit	// RTR or SRR until IDE tells which
);

	logic bit_valid;	// Destuffed sample

	assign bit_valid = sample_point & ~stuff_bit;

	// ==================================================
	// Field shift registers
	// ==================================================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			frame       <= '0;
			rtr_srr_bit <= RECESSIVE;
		end
		else if (bit_valid)
		begin
			case (state)
				st_idle:
					if (rx_bit == DOMINANT)
						frame <= '0;	// SOF clears so short fields read with leading zeros
				st_id_a:
					frame.id_a <= {frame.id_a[LEN_ID_A-2:0], rx_bit};
				st_rtr_srr:
					rtr_srr_bit <= rx_bit;
				st_ide:
				begin
					frame.ide <= rx_bit;
					frame.rtr <= rtr_srr_bit;	// Final for standard frames
				end
				st_id_b:
					frame.id_b <= {frame.id_b[LEN_ID_B-2:0], rx_bit};
				st_rtr:
					frame.rtr <= rx_bit;		// Extended frame RTR
				st_dlc:
				begin
					// MSB reaches bit 2 before the last shift
					if (frame.dlc[2])
						frame.dlc <= dlc_t'(MAX_DATA_BYTES);
					else
						frame.dlc <= {frame.dlc[2:0], rx_bit};
				end
				st_data:
					frame.data <= {frame.data[$bits(data_t)-2:0], rx_bit};
				st_crc:
					frame.crc <= {frame.crc[LEN_CRC-2:0], rx_bit};
				default:
				begin
					// Delimiters, ACK, EOF and the error frame carry no payload
				end
			endcase
		end
	end

endmodule

// ==== source/can_frame_fsm.sv ====
`timescale 1ns/1ps

module can_frame_fsm
	import can_frame_pkg::*;
	import can_decoder_pkg::*;
#(
	parameter int FLAGS_MIN = 6,	// Shortest error flag
	parameter int FLAGS_MAX = 12,	// Longest superposed error flag
	parameter int DELIM_LEN = 8
)
(
	input  logic           clock,
	input  logic           reset,
	input  logic           rx_bit,
	input  logic           sample_point,
	input  logic           stuff_bit,
	input  logic           stuff_error,
	input  field_len_t     bit_count,
	input  crc_t           crc,			// Computed over the frame
	input  crc_t           rx_crc,		// Taken from the CRC field
	input  dlc_t           dlc,			// DLC bits captured so far
	input  logic           ide,
	input  logic           rtr_srr_bit,	// Bit right after the base identifier
	output decoder_state_t state,
	output logic           stuff_active,
	output logic           crc_clear,
	output logic           crc_enable,
	output logic           frame_received,
	output logic           error_out
);

	// Last bit index of each fixed field
	localparam field_len_t LAST_ID_A  = field_len_t'(LEN_ID_A - 1);
	localparam field_len_t LAST_ID_B  = field_len_t'(LEN_ID_B - 1);
	localparam field_len_t LAST_DLC   = field_len_t'(LEN_DLC - 1);
	localparam field_len_t LAST_CRC   = field_len_t'(LEN_CRC - 1);
	localparam field_len_t LAST_EOF   = field_len_t'(LEN_EOF - 1);
	localparam field_len_t LAST_IFS   = field_len_t'(LEN_INTERMISSION - 1);
	localparam field_len_t MIN_FLAGS  = field_len_t'(FLAGS_MIN);
	localparam field_len_t LAST_FLAG  = field_len_t'(FLAGS_MAX - 1);
	localparam field_len_t LAST_DELIM = field_len_t'(DELIM_LEN - 1);

	decoder_state_t next_state;
	error_cause_t   error_cause;	// Error found on this sample
	logic           bit_valid;		// Sampled, not a stuff bit
	logic           sof;			// Dominant sample while idle
	logic           ext_rtr;		// RTR bit of an extended frame
	logic           remote;
	dlc_t           dlc_full;		// DLC including the current bit
	field_len_t     data_len;		// Data field length in bits
	logic           crc_field;		// Fields covered by the CRC

	assign bit_valid = sample_point & ~stuff_bit;
	assign sof       = sample_point & (state == st_idle) & (rx_bit == DOMINANT);
	assign dlc_full  = {dlc[2:0], rx_bit};
	assign data_len  = {dlc, 3'b000};
	assign remote    = ide ? ext_rtr : rtr_srr_bit;

	// ==================================================
	// Next state and error detection
	// ==================================================

	always_comb
	begin
		next_state  = state;
		error_cause = err_none;
		if (stuff_error)
			error_cause = err_stuff;
		else if (bit_valid)
		begin
			case (state)
				st_idle:
					if (rx_bit == DOMINANT)
						next_state = st_id_a;	// SOF
				st_id_a:
					if (bit_count == LAST_ID_A)
						next_state = st_rtr_srr;
				st_rtr_srr:
					next_state = st_ide;
				st_ide:
					if (rx_bit == DOMINANT)
						next_state = st_reserved0;	// Standard frame
					else if (rtr_srr_bit == DOMINANT)
						error_cause = err_form;		// SRR must be recessive
					else
						next_state = st_id_b;
				st_id_b:
					if (bit_count == LAST_ID_B)
						next_state = st_rtr;
				st_rtr:
					next_state = st_reserved1;
				st_reserved1:
					next_state = st_reserved0;
				st_reserved0:
					next_state = st_dlc;
				st_dlc:
					if (bit_count == LAST_DLC)	// Skip data for remote or empty frames
						next_state = (remote || dlc_full == '0) ? st_crc : st_data;
				st_data:
					if (bit_count == data_len - 7'd1)
						next_state = st_crc;
				st_crc:
					if (bit_count == LAST_CRC)
						next_state = st_crc_delim;
				st_crc_delim:
					if (rx_bit == DOMINANT)
						error_cause = err_form;
					else if (crc != rx_crc)
						error_cause = err_crc;
					else
						next_state = st_ack_slot;
				st_ack_slot:
					if (rx_bit == RECESSIVE)
						error_cause = err_form;	// Nobody acknowledged
					else
						next_state = st_ack_delim;
				st_ack_delim:
					if (rx_bit == DOMINANT)
						error_cause = err_form;
					else
						next_state = st_eof;
				st_eof:
					if (rx_bit == DOMINANT)
						error_cause = err_form;
					else if (bit_count == LAST_EOF)
						next_state = st_intermission;
				st_intermission:
					if (rx_bit == DOMINANT)
						error_cause = err_form;	// No overload frames here
					else if (bit_count == LAST_IFS)
						next_state = st_idle;
				st_error_flags:
					if (rx_bit == RECESSIVE)
					begin
						// Early recessive bits are ignored
						if (bit_count >= MIN_FLAGS && bit_count <= LAST_FLAG)
							next_state = st_error_delim;
					end
					else if (bit_count == LAST_FLAG)
						next_state = st_idle;	// Over-long flag resyncs through idle
				st_error_delim:
					if (rx_bit == DOMINANT)
						error_cause = err_form;	// Starts a fresh error frame
					else if (bit_count == LAST_DELIM)
						next_state = st_idle;
				default:
					next_state = st_idle;
			endcase
		end

		if (error_cause != err_none)
			next_state = st_error_flags;
	end

	// ==================================================
	// State and output strobes
	// ==================================================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state          <= st_idle;
			frame_received <= 1'b0;
			error_out      <= 1'b0;
			ext_rtr        <= 1'b0;
		end
		else
		begin
			state          <= next_state;
			error_out      <= (error_cause != err_none);
			frame_received <= (state == st_eof) && (next_state == st_intermission);
			if (bit_valid && state == st_rtr)
				ext_rtr <= rx_bit;
		end
	end

	// Includes the possible stuff bit after the last CRC bit
	assign stuff_active = state inside {st_id_a, st_rtr_srr, st_ide, st_id_b, st_rtr,
		st_reserved1, st_reserved0, st_dlc, st_data, st_crc, st_crc_delim};

	assign crc_field = state inside {st_id_a, st_rtr_srr, st_ide, st_id_b, st_rtr,
		st_reserved1, st_reserved0, st_dlc, st_data};

	assign crc_clear  = (state == st_idle) & ~sof;
	assign crc_enable = sof | (crc_field & ~stuff_bit);	// Sampled in the CRC block

	assert property (@(posedge clock) disable iff (reset) !(error_out && frame_received));

endmodule

// ==== source/can_frame_pkg.sv ====
package can_frame_pkg;

	// ==================================================
	// Field lengths
	// ==================================================

	localparam int LEN_ID_A         = 11;	// Base identifier
	localparam int LEN_ID_B         = 18;	// Identifier extension
	localparam int LEN_DLC          = 4;
	localparam int LEN_CRC          = 15;
	localparam int LEN_EOF          = 7;	// Recessive end of frame
	localparam int LEN_INTERMISSION = 2;	// Third bit may already be the next SOF
	localparam int MAX_DATA_BYTES   = 8;	// Larger DLC codes still mean 8 bytes

	// ==================================================
	// Field types
	// ==================================================

	typedef logic [LEN_ID_A-1:0]         id_a_t;
	typedef logic [LEN_ID_B-1:0]         id_b_t;
	typedef logic [LEN_DLC-1:0]          dlc_t;
	typedef logic [MAX_DATA_BYTES*8-1:0] data_t;	// First received bit on top
	typedef logic [LEN_CRC-1:0]          crc_t;

	// x^15 + x^14 + x^10 + x^8 + x^7 + x^4 + x^3 + 1
	localparam crc_t CRC_POLY = 15'h4599;

	// Decoded frame as it leaves the decoder
	typedef struct packed {
		id_a_t id_a;
		logic  ide;		// Recessive for extended frames
		logic  rtr;		// Recessive for remote frames
		id_b_t id_b;	// Zero in standard frames
		dlc_t  dlc;		// Already clamped
		data_t data;	// Right aligned
		crc_t  crc;		// As received
	} can_frame_t;

endpackage

// ==== tests/can_decoder_checker.sv ====
`timescale 1ns/1ps

module can_decoder_checker
	import can_frame_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  can_frame_t frame,			// DUT outputs
	input  logic       frame_received,
	input  logic       error_out,
	input  can_frame_t expected,		// Decoded frame of the current test
	input  logic       expect_frame,
	input  logic       expect_error,
	input  logic       check_end,		// Closes the current test window
	input  int         test_id,
	output int         mismatch_count,
	output int         event_count		// Missing or unexpected strobes
);

	int frames_seen;	// Strobes inside the open window
	int errors_seen;

	function automatic string test_name(input int id);
		case (id)
			1: return "std_data";
			2: return "ext_data";
			3: return "remote";
			4: return "crc_error";
			5: return "stuff_error";
			6: return "eof_form_error";
			7: return "recovery";
			default: return "unknown";
		endcase
	endfunction

	task automatic compare_field(input string field, input logic [63:0] exp_value,
		input logic [63:0] act_value);
		if (exp_value !== act_value)
		begin
			$display("mismatch %s.%s expected %h actual %h", test_name(test_id), field,
				exp_value, act_value);
			mismatch_count++;
		end
	endtask

	// ==================================================
	// Strobe watch and frame compare
	// ==================================================

	// Registered DUT strobes are read as they were before this edge
	always @(posedge clock)
	begin
		if (reset)
		begin
			mismatch_count = 0;
			event_count    = 0;
			frames_seen    = 0;
			errors_seen    = 0;
		end
		else
		begin
			if (frame_received)
			begin
				frames_seen++;
				if (!expect_frame)
				begin
					$display("Unexpected frame_received in test %s", test_name(test_id));
					event_count++;
				end
				else
				begin
					compare_field("id_a", 64'(expected.id_a), 64'(frame.id_a));
					compare_field("ide", 64'(expected.ide), 64'(frame.ide));
					compare_field("rtr", 64'(expected.rtr), 64'(frame.rtr));
					compare_field("id_b", 64'(expected.id_b), 64'(frame.id_b));
					compare_field("dlc", 64'(expected.dlc), 64'(frame.dlc));
					compare_field("data", expected.data, frame.data);
					compare_field("crc", 64'(expected.crc), 64'(frame.crc));
				end
			end
			if (error_out)
			begin
				errors_seen++;
				if (!expect_error)
				begin
					$display("Unexpected error_out in test %s", test_name(test_id));
					event_count++;
				end
			end
			if (check_end)
			begin
				if (expect_frame && frames_seen != 1)
				begin
					$display("Test %s wanted one frame_received but saw %0d",
						test_name(test_id), frames_seen);
					event_count++;
				end
				if (expect_error && errors_seen != 1)
				begin
					$display("Test %s wanted one error_out but saw %0d",
						test_name(test_id), errors_seen);
					event_count++;
				end
				frames_seen = 0;	// Fresh window
				errors_seen = 0;
			end
		end
	end

endmodule

// ==== tests/can_decoder_tb.sv ====
`timescale 1ns/1ps

module can_decoder_tb
	import can_frame_pkg::*;
	import can_decoder_pkg::*;
();

	localparam int CLOCK_PERIOD = 100;
	localparam int NUM_STD      = 8;
	localparam int NUM_EXT      = 6;
	localparam int NUM_RTR      = 4;
	localparam int NUM_ERR      = 3;	// Each one followed by a recovery frame
	localparam int TOTAL_FRAMES = NUM_STD + NUM_EXT + NUM_RTR + 2 * NUM_ERR;
	localparam int WATCHDOG_NS  = 2 * TOTAL_FRAMES * 160 * 4 * CLOCK_PERIOD;

	typedef logic bit_q_t [$];	// Raw bus bits, first on the bus at index 0

	logic       clock;
	logic       reset;
	logic       rx_bit;
	logic       sample_point;
	can_frame_t frame;
	logic       frame_received;
	logic       error_out;
	can_frame_t expected;		// Decoded frame the scoreboard waits for
	logic       expect_frame;
	logic       expect_error;
	logic       check_end;
	int         test_id;
	int         mismatch_count;
	int         event_count;
	integer     seed;

	can_decoder #(
		.FLAGS_MIN (6),
		.FLAGS_MAX (12),
		.DELIM_LEN (8)
	) DUT (
		.clock          (clock),
		.reset          (reset),
		.rx_bit         (rx_bit),
		.sample_point   (sample_point),
		.frame          (frame),
		.frame_received (frame_received),
		.error_out      (error_out)
	);

	can_decoder_checker scoreboard (
		.clock          (clock),
		.reset          (reset),
		.frame          (frame),
		.frame_received (frame_received),
		.error_out      (error_out),
		.expected       (expected),
		.expect_frame   (expect_frame),
		.expect_error   (expect_error),
		.check_end      (check_end),
		.test_id        (test_id),
		.mismatch_count (mismatch_count),
		.event_count    (event_count)
	);

	initial
	begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	// ==================================================
	// Reference frame builder
	// ==================================================

	// Bus bits of one frame up to the last EOF bit and the decoded view of it
	function automatic void build_frame(input logic [28:0] id, input logic ide, input logic rtr,
		input dlc_t dlc, input data_t data, input crc_t crc_flip,
		output bit_q_t bits, output can_frame_t golden);
		bit_q_t raw;		// SOF through CRC before stuffing
		crc_t   crc;
		int     nbits;
		int     run;
		logic   last;
		logic   feedback;
		golden     = '0;
		golden.ide = ide;
		golden.rtr = rtr;
		golden.dlc = (int'(dlc) > MAX_DATA_BYTES) ? dlc_t'(MAX_DATA_BYTES) : dlc;
		nbits      = rtr ? 0 : int'(golden.dlc) * 8;	// Remote frames carry no data
		if (ide)
		begin
			golden.id_a = id[28:18];
			golden.id_b = id[17:0];
		end
		else
			golden.id_a = id[10:0];
		for (int i = 0; i < nbits; i++)
			golden.data[i] = data[i];	// Right aligned
		raw = {};
		raw.push_back(DOMINANT);		// SOF
		for (int i = LEN_ID_A - 1; i >= 0; i--)
			raw.push_back(golden.id_a[i]);
		if (ide)
		begin
			raw.push_back(RECESSIVE);	// SRR
			raw.push_back(RECESSIVE);	// IDE
			for (int i = LEN_ID_B - 1; i >= 0; i--)
				raw.push_back(golden.id_b[i]);
			raw.push_back(rtr);
			raw.push_back(DOMINANT);	// r1
		end
		else
		begin
			raw.push_back(rtr);
			raw.push_back(DOMINANT);	// IDE
		end
		raw.push_back(DOMINANT);		// r0
		for (int i = LEN_DLC - 1; i >= 0; i--)
			raw.push_back(dlc[i]);		// Raw code before clamping
		for (int i = nbits - 1; i >= 0; i--)
			raw.push_back(data[i]);
		// CRC-15 from zero over SOF up to the last data bit
		crc = '0;
		foreach (raw[i])
		begin
			feedback = raw[i] ^ crc[LEN_CRC-1];
			crc      = {crc[LEN_CRC-2:0], 1'b0};
			if (feedback)
				crc ^= CRC_POLY;
		end
		golden.crc = crc ^ crc_flip;	// Flip mask corrupts the sent CRC
		for (int i = LEN_CRC - 1; i >= 0; i--)
			raw.push_back(golden.crc[i]);
		// Complement after five equal bits and let the stuff bit open the next run
		bits = {};
		last = RECESSIVE;
		run  = 0;
		foreach (raw[i])
		begin
			bits.push_back(raw[i]);
			if (raw[i] == last)
				run++;
			else
			begin
				last = raw[i];
				run  = 1;
			end
			if (run == 5)
			begin
				last = ~last;
				bits.push_back(last);
				run = 1;
			end
		end
		bits.push_back(RECESSIVE);		// CRC delimiter
		bits.push_back(DOMINANT);		// ACK from some receiver
		bits.push_back(RECESSIVE);		// ACK delimiter
		repeat (LEN_EOF) bits.push_back(RECESSIVE);
	endfunction

	// ==================================================
	// Bus driver
	// ==================================================

	// One bus bit of four clocks with the strobe on the first
	task automatic send_bit(input logic value);
		@(negedge clock);
		rx_bit       = value;
		sample_point = 1'b1;
		@(negedge clock);
		sample_point = 1'b0;
		repeat (2) @(negedge clock);
	endtask

	// Sends cut_len frame bits and the error frame if corrupt before bus idle
	task automatic run_frame(input int tid, input bit_q_t bits, input can_frame_t golden,
		input int cut_len, input logic corrupt);
		test_id      = tid;
		expected     = golden;
		expect_frame = ~corrupt;
		expect_error = corrupt;
		for (int i = 0; i < cut_len; i++)
			send_bit(bits[i]);
		if (corrupt)
		begin
			repeat (6) send_bit(DOMINANT);		// Error flag
			repeat (8) send_bit(RECESSIVE);		// Error delimiter
		end
		repeat (11) send_bit(RECESSIVE);		// Intermission and idle
		@(negedge clock);
		check_end = 1'b1;						// Scoreboard closes the window
		@(negedge clock);
		check_end = 1'b0;
	endtask

	function automatic dlc_t pick_dlc(input int n);
		case (n)
			0: return 4'd15;	// Clamps to 8
			1: return 4'd9;
			2: return 4'd0;		// Empty data field
			default: return dlc_t'($random(seed));
		endcase
	endfunction

	task automatic send_good_frame(input int tid, input logic ide, input logic rtr,
		input dlc_t dlc);
		logic [28:0] id;
		data_t       data;
		bit_q_t      bits;
		can_frame_t  golden;
		id   = 29'($random(seed));
		data = {$random(seed), $random(seed)};
		build_frame(id, ide, rtr, dlc, data, '0, bits, golden);
		run_frame(tid, bits, golden, bits.size(), 1'b0);
	endtask

	// ==================================================
	// Stimulus
	// ==================================================

	initial
	begin : stimulus
		data_t      data;
		bit_q_t     bits;
		can_frame_t golden;
		seed         = 32'hccd127e5;
		reset        = 1'b1;
		rx_bit       = RECESSIVE;
		sample_point = 1'b0;
		expected     = '0;
		expect_frame = 1'b0;
		expect_error = 1'b0;
		check_end    = 1'b0;
		test_id      = 0;
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		repeat (11) send_bit(RECESSIVE);	// Bus idle before the first SOF

		for (int n = 0; n < NUM_STD; n++)
			send_good_frame(1, 1'b0, 1'b0, pick_dlc(n));
		for (int n = 0; n < NUM_EXT; n++)
			send_good_frame(2, 1'b1, 1'b0, pick_dlc(n));
		for (int n = 0; n < NUM_RTR; n++)
			send_good_frame(3, n[0], 1'b1, dlc_t'($random(seed)));	// Both formats

		// One CRC bit flipped before stuffing and the frame cut after the delimiter
		data = {$random(seed), $random(seed)};
		build_frame(29'h2a5, 1'b0, 1'b0, 4'd4, data, 15'h0100, bits, golden);
		run_frame(4, bits, golden, bits.size() - 9, 1'b1);
		send_good_frame(7, 1'b0, 1'b0, 4'd2);

		// Six dominant bits inside the base identifier
		data = {$random(seed), $random(seed)};
		build_frame(29'h12345678, 1'b1, 1'b0, 4'd3, data, '0, bits, golden);
		repeat (6) bits.insert(4, DOMINANT);
		run_frame(5, bits, golden, 10, 1'b1);
		send_good_frame(7, 1'b1, 1'b0, 4'd8);

		// Fourth EOF bit forced dominant
		data = {$random(seed), $random(seed)};
		build_frame(29'h0f0, 1'b0, 1'b0, 4'd1, data, '0, bits, golden);
		bits[bits.size() - 4] = DOMINANT;
		run_frame(6, bits, golden, bits.size() - 3, 1'b1);
		send_good_frame(7, 1'b0, 1'b0, 4'd5);

		repeat (4) @(negedge clock);
		$display("Errors: %0d field mismatches, %0d strobe errors", mismatch_count, event_count);
		if (mismatch_count == 0 && event_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// Twice the time of the longest possible run
	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before all frames were sent");
		$display("Result: FAILED");
		$finish;
	end

endmodule
